//--- hw/bgPkg.sv
package bgPkg;

  ////////////////////
  // Scan geometry, 640x480 raster
  ////////////////////

  // Horizontal, in pixels
  localparam logic [9:0] hActive     = 10'd640;
  localparam logic [9:0] hFrontPorch = 10'd16;
  localparam logic [9:0] hSyncLen    = 10'd96;
  localparam logic [9:0] hTotal      = 10'd800;

  // Vertical, in lines
  localparam logic [9:0] vActive     = 10'd480;
  localparam logic [9:0] vFrontPorch = 10'd10;
  localparam logic [9:0] vSyncLen    = 10'd2;
  localparam logic [9:0] vTotal      = 10'd525;

  // Derived sync windows, end is exclusive
  localparam logic [9:0] hSyncStart = hActive + hFrontPorch;
  localparam logic [9:0] hSyncEnd   = hSyncStart + hSyncLen;
  localparam logic [9:0] vSyncStart = vActive + vFrontPorch;
  localparam logic [9:0] vSyncEnd   = vSyncStart + vSyncLen;

  // Last counter values before wrap
  localparam logic [9:0] hLast = hTotal - 10'd1;
  localparam logic [9:0] vLast = vTotal - 10'd1;

  ////////////////////
  // Background bands, row numbers
  ////////////////////
  localparam logic [9:0] skyEnd    = 10'd429;
  localparam logic [9:0] dirtLine  = 10'd429;
  localparam logic [9:0] grassTop  = 10'd430;
  localparam logic [9:0] groundTop = 10'd450;

  // Stripe lit for phase 0..8 of every 16
  localparam int         stripePeriod = 16;
  localparam logic [3:0] stripeOn     = 4'd8;

  ////////////////////
  // Types
  ////////////////////
  typedef logic [9:0] coordT;
  typedef logic [3:0] offsetT;
  typedef logic [1:0] speedT;

  // Host register map
  typedef enum logic [1:0] {
    regCtrl  = 2'd0,
    regSpeed = 2'd1
  } regAddrT;

  // Scan position with its syncs, 23 bits
  typedef struct packed {
    coordT x;
    coordT y;
    logic  active;
    logic  hSyncN;
    logic  vSyncN;
  } scanT;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgbT;

  // Output pixel, colour plus aligned scan
  typedef struct packed {
    rgbT  rgb;
    scanT scan;
  } pixelT;

  typedef struct packed {
    logic  run;
    speedT speed;
  } bgCfgT;

  // Scan state out of reset, syncs idle high
  localparam scanT scanReset = '{x: 10'd0, y: 10'd0, active: 1'b0, hSyncN: 1'b1, vSyncN: 1'b1};

endpackage

//--- hw/scanTiming.sv
module scanTiming (
  input  logic        Clks,
  input  logic        rstN,
  output bgPkg::scanT scan,
  output logic        frameEnd
);

  import bgPkg::*;

  ////////////////////
  // Next counter values
  ////////////////////
  coordT xNext;
  coordT yNext;
  logic  lineEnd;
  logic  hSyncNext;
  logic  vSyncNext;
  logic  activeNext;

  // Last pixel of the line
  assign lineEnd = (scan.x == hLast);

  always_comb
  begin
    // x wraps at 799
    if (lineEnd)
    begin
      xNext = '0;
    end
    else
    begin
      xNext = scan.x + 10'd1;
    end

    // y only moves on the x wrap
    yNext = scan.y;
    if (lineEnd)
    begin
      if (scan.y == vLast)
      begin
        yNext = '0;
      end
      else
      begin
        yNext = scan.y + 10'd1;
      end
    end
  end

  // Syncs and active from next values, so they land with the counters
  assign hSyncNext  = (xNext >= hSyncStart) && (xNext < hSyncEnd);
  assign vSyncNext  = (yNext >= vSyncStart) && (yNext < vSyncEnd);
  assign activeNext = (xNext < hActive) && (yNext < vActive);

  ////////////////////
  // Scan register
  ////////////////////
  always_ff @(posedge Clks)
  begin
    if (!rstN)
    begin
      scan <= scanReset;
    end
    else
    begin
      scan.x      <= xNext;
      scan.y      <= yNext;
      scan.active <= activeNext;
      // Both syncs active low
      scan.hSyncN <= !hSyncNext;
      scan.vSyncN <= !vSyncNext;
    end
  end

  // Last pixel of the frame
  assign frameEnd = lineEnd && (scan.y == vLast);

endmodule

//--- hw/bgRegs.sv
module bgRegs (
  input  logic           Clks,
  input  logic           rstN,
  input  logic           regWr,
  input  bgPkg::regAddrT regAddr,
  input  logic [7:0]     regData,
  output bgPkg::bgCfgT   cfg
);

  import bgPkg::*;

  ////////////////////
  // Stored fields
  ////////////////////

  // Game running, scroll enabled
  logic  runQ;
  // Offset step per frame
  speedT speedQ;

  // Write decode
  logic ctrlWr;
  logic speedWr;

  always_comb
  begin
    ctrlWr  = 1'b0;
    speedWr = 1'b0;
    if (regWr)
    begin
      case (regAddr)
        regCtrl:  ctrlWr  = 1'b1;
        regSpeed: speedWr = 1'b1;
        // Unmapped addresses dropped
        default:  ;
      endcase
    end
  end

  always_ff @(posedge Clks)
  begin
    if (!rstN)
    begin
      runQ   <= 1'b0;
      speedQ <= '0;
    end
    else
    begin
      if (ctrlWr)
      begin
        runQ <= regData[0];
      end
      if (speedWr)
      begin
        speedQ <= regData[1:0];
      end
    end
  end

  // Visible the cycle after the strobe
  assign cfg = '{run: runQ, speed: speedQ};

endmodule

//--- hw/drawBackground.sv
module drawBackground (
  input  logic         Clks,
  input  logic         rstN,
  input  bgPkg::scanT  scan,
  input  logic         frameEnd,
  input  bgPkg::bgCfgT cfg,
  output bgPkg::pixelT pixel
);

  import bgPkg::*;

  ////////////////////
  // Grass scroll offset
  ////////////////////
  offsetT offset;

  // One offset per frame, stepped on the last pixel
  always_ff @(posedge Clks)
  begin
    if (!rstN)
    begin
      offset <= '0;
    end
    else if (frameEnd && cfg.run)
    begin
      // Wraps at 16 by width
      offset <= offset + offsetT'(cfg.speed);
    end
  end

  ////////////////////
  // Band classification
  ////////////////////
  logic   sky;
  logic   dirt;
  logic   grass;
  logic   ground;
  logic   stripe;
  coordT  phaseSum;
  offsetT phase;

  // Rows only, active gating comes later
  assign sky    = (scan.y < skyEnd);
  assign dirt   = (scan.y == dirtLine);
  assign grass  = (scan.y >= grassTop) && (scan.y < groundTop);
  assign ground = (scan.y >= groundTop) && (scan.y < vActive);

  // Diagonal phase, half slope in y
  // Overflow past 1023 keeps the low 4 bits intact
  assign phaseSum = scan.x + (scan.y >> 1) + coordT'(offset);
  assign phase    = offsetT'(phaseSum % stripePeriod);

  // Lit part of each stripe period
  assign stripe = grass && (phase <= stripeOn);

  ////////////////////
  // Colour
  ////////////////////
  rgbT colour;

  always_comb
  begin
    colour = '0;
    if (scan.active)
    begin
      // Red adds the fine checker in the sky
      colour.r = stripe | ground | (scan.x[0] ^ scan.y[0]);
      colour.g = sky | dirt | grass | ground;
      colour.b = sky | stripe;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // Colour and its scan position leave together, one cycle late
  always_ff @(posedge Clks)
  begin
    if (!rstN)
    begin
      pixel.rgb  <= '0;
      pixel.scan <= scanReset;
    end
    else
    begin
      pixel.rgb  <= colour;
      pixel.scan <= scan;
    end
  end

endmodule

//--- hw/bgTop.sv
module bgTop (
  input  logic           Clks,
  input  logic           rstN,
  input  logic           regWr,
  input  bgPkg::regAddrT regAddr,
  input  logic [7:0]     regData,
  output bgPkg::pixelT   pixel
);

  import bgPkg::*;

  ////////////////////
  // Internal wires
  ////////////////////
  scanT  scan;
  logic  frameEnd;
  bgCfgT cfg;

  // Raster counters and syncs
  scanTiming i_scanTiming (
    .Clks     (Clks),
    .rstN     (rstN),
    .scan     (scan),
    .frameEnd (frameEnd)
  );

  // Host configuration
  bgRegs i_bgRegs (
    .Clks    (Clks),
    .rstN    (rstN),
    .regWr   (regWr),
    .regAddr (regAddr),
    .regData (regData),
    .cfg     (cfg)
  );

  // Background colour, one cycle behind the scan
  drawBackground i_drawBackground (
    .Clks     (Clks),
    .rstN     (rstN),
    .scan     (scan),
    .frameEnd (frameEnd),
    .cfg      (cfg),
    .pixel    (pixel)
  );

endmodule

//--- dv/clockGen.sv
module clockGen (
  output logic Clks
);

  // Free-running clock, 40 time units per period
  initial
  begin
    Clks = 1'b0;
    forever
    begin
      // Half period
      #20 Clks = ~Clks;
    end
  end

endmodule

//--- dv/tbBgTop.sv
module tbBgTop;

  import bgPkg::*;

  // Cycles allowed for one frame wait, a frame is 420000
  localparam int frameTimeout = 430000;

  ////////////////////
  // DUT signals
  ////////////////////
  logic       Clks;
  logic       rstN;
  logic       regWr;
  regAddrT    regAddr;
  logic [7:0] regData;
  pixelT      pixel;

  integer seed;
  // Offset that the next checked frame should use
  offsetT expOffset;

  clockGen i_clockGen (
    .Clks (Clks)
  );

  bgTop i_bgTop (
    .Clks    (Clks),
    .rstN    (rstN),
    .regWr   (regWr),
    .regAddr (regAddr),
    .regData (regData),
    .pixel   (pixel)
  );

  ////////////////////
  // Basic helpers
  ////////////////////

  // Past the rising edge, outputs settled, safe to drive
  task automatic stepCycle();
    @(posedge Clks);
    #5;
  endtask

  task automatic failNow(string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  // One-cycle write strobe
  task automatic writeReg(regAddrT addr, logic [7:0] data);
    regWr   = 1'b1;
    regAddr = addr;
    regData = data;
    stepCycle();
    regWr   = 1'b0;
    regData = '0;
  endtask

  // Step until the output shows the top left pixel
  task automatic waitFrame();
    int cycles;
    cycles = 0;
    do
    begin
      stepCycle();
      cycles++;
      if (cycles > frameTimeout)
      begin
        $display("The wait for the start of a frame ran out after %0d cycles", frameTimeout);
        $display("test failed");
        $fatal(1, "frame wait timeout");
      end
    end
    while (!(pixel.scan.x == '0 && pixel.scan.y == '0));
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Raster position with its syncs, 800x525 with 656..751 and 490..491 sync
  function automatic scanT refScan(int x, int y);
    scanT s;
    s.x      = coordT'(x);
    s.y      = coordT'(y);
    s.active = (x < 640) && (y < 480);
    s.hSyncN = !((x >= 656) && (x <= 751));
    s.vSyncN = !((y == 490) || (y == 491));
    return s;
  endfunction

  function automatic rgbT refColour(int x, int y, offsetT off);
    rgbT  c;
    logic sky;
    logic dirt;
    logic grass;
    logic ground;
    logic stripe;
    int   phase;
    c = '0;
    // Black outside the visible area
    if ((x < 640) && (y < 480))
    begin
      sky    = (y < 429);
      dirt   = (y == 429);
      grass  = (y >= 430) && (y <= 449);
      ground = (y >= 450);
      // Diagonal stripes, half slope in y
      phase  = (x + y / 2 + int'(off)) % 16;
      stripe = grass && (phase <= 8);
      c.r = stripe | ground | ((x % 2) != (y % 2));
      c.g = sky | dirt | grass | ground;
      c.b = sky | stripe;
    end
    return c;
  endfunction

  // Which offset gives the blue pattern seen on row 430, x 0..15
  function automatic offsetT matchOffset(logic [15:0] lit);
    offsetT found;
    logic   same;
    rgbT    c;
    int     off;
    int     x;
    found = '0;
    for (off = 0; off < 16; off++)
    begin
      same = 1'b1;
      for (x = 0; x < 16; x++)
      begin
        c = refColour(x, 430, offsetT'(off));
        if (c.b != lit[x])
        begin
          same = 1'b0;
        end
      end
      if (same)
      begin
        found = offsetT'(off);
      end
    end
    return found;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic compareRgb(rgbT got, rgbT exp, int x, int y);
    if (got !== exp)
    begin
      failNow($sformatf("colour at x=%0d y=%0d is %b, expected %b", x, y, got, exp));
    end
  endtask

  task automatic compareScan(scanT got, scanT exp);
    if (got !== exp)
    begin
      failNow($sformatf("scan x=%0d y=%0d a/h/v=%b%b%b, expected x=%0d y=%0d a/h/v=%b%b%b",
                        got.x, got.y, got.active, got.hSyncN, got.vSyncN,
                        exp.x, exp.y, exp.active, exp.hSyncN, exp.vSyncN));
    end
  endtask

  task automatic compareOffset(offsetT got, offsetT exp, string what);
    if (got !== exp)
    begin
      failNow($sformatf("%s offset is %0d, expected %0d", what, got, exp));
    end
  endtask

  // Walks rows 0..lastRow from the top left pixel, colour checked from firstRow
  task automatic sweepRows(int firstRow, int lastRow, offsetT off, string what);
    int          x;
    int          y;
    int          i;
    logic [15:0] lit;
    rgbT         head [16];
    lit = '0;
    for (y = 0; y <= lastRow; y++)
    begin
      for (x = 0; x < 800; x++)
      begin
        // Output already on x=0, y=0 at entry
        if (x != 0 || y != 0)
        begin
          stepCycle();
        end
        compareScan(pixel.scan, refScan(x, y));
        if (y == 430 && x < 16)
        begin
          // Start of the first grass row, held until its offset is known
          lit[x]  = pixel.rgb.b;
          head[x] = pixel.rgb;
        end
        else if (y >= firstRow)
        begin
          compareRgb(pixel.rgb, refColour(x, y, off), x, y);
        end
        if (y == 430 && x == 15 && firstRow <= 430)
        begin
          compareOffset(matchOffset(lit), off, what);
          for (i = 0; i < 16; i++)
          begin
            compareRgb(head[i], refColour(i, 430, off), i, 430);
          end
        end
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic resetTest();
    scanT exp;
    int   i;
    stepCycle();
    // Scan register leaves reset with active clear
    exp        = refScan(0, 0);
    exp.active = 1'b0;
    compareScan(pixel.scan, exp);
    compareRgb(pixel.rgb, '0, 0, 0);
    for (i = 1; i < 20; i++)
    begin
      stepCycle();
      compareScan(pixel.scan, refScan(i, 0));
    end
  endtask

  // Full frame, syncs and active only
  task automatic syncTest();
    waitFrame();
    sweepRows(525, 524, expOffset, "sync frame");
  endtask

  task automatic staticTest();
    waitFrame();
    sweepRows(0, 524, expOffset, "static frame");
  endtask

  task automatic scrollTest();
    int k;
    // Write early in a frame, applied at its last pixel
    waitFrame();
    writeReg(regSpeed, 8'd1);
    writeReg(regCtrl, 8'd1);
    for (k = 1; k <= 3; k++)
    begin
      waitFrame();
      expOffset = expOffset + 4'd1;
      sweepRows(430, 449, expOffset, $sformatf("scroll frame %0d", k));
    end
  endtask

  task automatic speedStopTest();
    offsetT held;
    speedT  spd;
    int     k;
    // Still mid frame on row 449 here
    spd = speedT'($random(seed));
    writeReg(regSpeed, {6'd0, spd});
    waitFrame();
    expOffset = expOffset + offsetT'(spd);
    sweepRows(430, 449, expOffset, $sformatf("speed %0d frame", spd));
    // Non-zero step, so a missed stop would move the stripes
    writeReg(regSpeed, 8'd1);
    // Stopped, offset must freeze
    writeReg(regCtrl, 8'd0);
    held = expOffset;
    for (k = 1; k <= 2; k++)
    begin
      waitFrame();
      sweepRows(430, 449, held, $sformatf("stopped frame %0d", k));
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////
  initial
  begin
    seed      = 21052;
    expOffset = '0;
    rstN      = 1'b0;
    regWr     = 1'b0;
    regAddr   = regCtrl;
    regData   = '0;
    // Four clocks in reset
    repeat (4) stepCycle();
    rstN = 1'b1;
    resetTest();
    syncTest();
    staticTest();
    scrollTest();
    speedStopTest();
    $display("test passed");
    $finish;
  end

endmodule

//--- src.f
hw/bgPkg.sv
hw/scanTiming.sv
hw/bgRegs.sv
hw/drawBackground.sv
hw/bgTop.sv
dv/clockGen.sv
dv/tbBgTop.sv

//--- Makefile
# Verilator build and run for the background layer testbench

VERILATOR ?= verilator
TOP       ?= tbBgTop
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the pass line appears in the output
test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
